// File: hdl/carry_pkg.sv
// Carry stage package with widths, lane record and FSM state types
`default_nettype none

package carry_pkg;

  // ------------------------------
  // Widths and lane count
  // ------------------------------
  localparam int byte_w     = 8;
  localparam int num_lanes  = 3;
  // Lane count runs 0..num_lanes
  localparam int lane_cnt_w = 2;

  // One coded byte with the carry it brings into the held byte
  typedef struct packed {
    logic              carry;
    logic [byte_w-1:0] data;
  } lane_t;

  // ------------------------------
  // FSM states
  // ------------------------------
  // Resolver
  typedef enum logic [1:0] {
    res_idle    = 2'd0,
    res_scan    = 2'd1,
    res_release = 2'd2,
    res_flush   = 2'd3
  } res_state_t;

  // Emitter
  typedef enum logic [1:0] {
    emit_idle     = 2'd0,
    emit_req      = 2'd1,
    emit_ack_wait = 2'd2,
    emit_done     = 2'd3
  } emit_state_t;

endpackage

`default_nettype wire

// File: hdl/lane_bundle_if.sv
// Compacted lane bundle link from compactor to resolver, four-phase handshake
`timescale 1ns/100ps
`default_nettype none

interface lane_bundle_if;

  logic                              req;
  logic                              ack;
  // Number of valid lanes, packed from lane 0 upward
  logic [carry_pkg::lane_cnt_w-1:0]  count;
  carry_pkg::lane_t                  lanes [carry_pkg::num_lanes];
  // Stream ends with this bundle
  logic                              last;

  modport producer (
    output req, count, lanes, last,
    input  ack
  );

  modport consumer (
    input  req, count, lanes, last,
    output ack
  );

endinterface

`default_nettype wire

// File: hdl/release_if.sv
// Release command link from resolver to emitter, four-phase handshake
`timescale 1ns/100ps
`default_nettype none

interface release_if #(
  parameter int RUN_WIDTH = 8
);

  logic                         req;
  logic                         ack;
  // First byte of the command
  logic [carry_pkg::byte_w-1:0] head;
  // Byte repeated count times after head
  logic [carry_pkg::byte_w-1:0] fill;
  logic [RUN_WIDTH-1:0]         count;
  // Last byte of this command ends the stream
  logic                         final_flag;

  modport producer (
    output req, head, fill, count, final_flag,
    input  ack
  );

  modport consumer (
    input  req, head, fill, count, final_flag,
    output ack
  );

endinterface

`default_nettype wire

// File: hdl/lane_compactor.sv
// Lane compactor, captures input bundles and packs valid lanes to the front
`timescale 1ns/100ps
`default_nettype none

module lane_compactor (
  input  logic                                             s4_clk,
  input  logic                                             rst,
  input  logic                                             in_req,
  output logic                                             in_ack,
  input  logic [carry_pkg::num_lanes-1:0]                  in_valid,
  input  logic [carry_pkg::num_lanes-1:0]                  in_carry,
  input  logic [carry_pkg::num_lanes*carry_pkg::byte_w-1:0] in_data,
  input  logic                                             in_last,
  lane_bundle_if.producer                                  bundle
);

  logic                             full;
  logic                             ack_pend;
  logic                             capture;
  carry_pkg::lane_t                 packed_lanes [carry_pkg::num_lanes];
  logic [carry_pkg::lane_cnt_w-1:0] packed_cnt;

  // New bundle only once the previous handshake has closed
  assign capture = in_req && !in_ack && !full;

  // ------------------------------
  // Compaction
  // ------------------------------
  always_comb begin
    packed_cnt = '0;
    for (int i = 0; i < carry_pkg::num_lanes; i++) begin
      packed_lanes[i] = '0;
    end
    for (int i = 0; i < carry_pkg::num_lanes; i++) begin
      if (in_valid[i]) begin
        packed_lanes[packed_cnt].carry = in_carry[i];
        packed_lanes[packed_cnt].data  = in_data[i*carry_pkg::byte_w +: carry_pkg::byte_w];
        packed_cnt = packed_cnt + 1'b1;
      end
    end
  end

  // ------------------------------
  // Handshakes
  // ------------------------------
  always_ff @(posedge s4_clk) begin
    if (rst) begin
      full       <= 1'b0;
      ack_pend   <= 1'b0;
      in_ack     <= 1'b0;
      bundle.req <= 1'b0;
    end else begin
      if (capture) begin
        full     <= 1'b1;
        ack_pend <= 1'b1;
      end else if (ack_pend) begin
        ack_pend   <= 1'b0;
        in_ack     <= 1'b1;
        bundle.req <= 1'b1;
      end else if (full && bundle.req && bundle.ack) begin
        bundle.req <= 1'b0;
      end else if (full && !bundle.req && !bundle.ack) begin
        // Resolver has closed the bundle handshake
        full <= 1'b0;
      end
      if (in_ack && !in_req) begin
        in_ack <= 1'b0;
      end
    end
  end

  // Bundle register
  always_ff @(posedge s4_clk) begin
    if (capture) begin
      bundle.lanes <= packed_lanes;
      bundle.count <= packed_cnt;
      bundle.last  <= in_last;
    end
  end

  // Count in range and held for the whole bundle handshake
  a_count_ok : assert property (@(posedge s4_clk) disable iff (rst)
    bundle.req |-> (bundle.count <= carry_pkg::num_lanes) && $stable(bundle.count));

endmodule

`default_nettype wire

// File: hdl/carry_resolver.sv
// Carry resolver, applies the carry rule one lane per cycle and issues releases
`timescale 1ns/100ps
`default_nettype none

module carry_resolver #(
  parameter int RUN_WIDTH = 8
) (
  input  logic            s4_clk,
  input  logic            rst,
  lane_bundle_if.consumer bundle,
  release_if.producer     rel
);

  carry_pkg::res_state_t            state;
  // Held byte, still open to a later carry
  logic [carry_pkg::byte_w-1:0]     p;
  logic                             held;
  // Held 0xFF bytes behind p
  logic [RUN_WIDTH-1:0]             n;
  logic [carry_pkg::lane_cnt_w-1:0] idx;
  carry_pkg::lane_t                 cur;
  logic                             lanes_done;
  logic                             is_ff;
  logic                             run_inc;

  // Lane under scan
  always_comb begin
    cur = '0;
    for (int i = 0; i < carry_pkg::num_lanes; i++) begin
      if (idx == i) begin
        cur = bundle.lanes[i];
      end
    end
  end

  assign lanes_done = (idx == bundle.count);
  assign is_ff      = (cur.data == {carry_pkg::byte_w{1'b1}});
  assign run_inc    = (state == carry_pkg::res_scan) && !lanes_done && held &&
                      !cur.carry && is_ff;

  // ------------------------------
  // Control FSM
  // ------------------------------
  always_ff @(posedge s4_clk) begin
    if (rst) begin
      state      <= carry_pkg::res_idle;
      held       <= 1'b0;
      n          <= '0;
      idx        <= '0;
      bundle.ack <= 1'b0;
      rel.req    <= 1'b0;
    end else begin
      case (state)
        carry_pkg::res_idle: begin
          if (bundle.ack && !bundle.req) begin
            bundle.ack <= 1'b0;
          end else if (bundle.req && !bundle.ack) begin
            idx   <= '0;
            state <= carry_pkg::res_scan;
          end
        end

        carry_pkg::res_scan: begin
          if (lanes_done) begin
            if (bundle.last && held) begin
              // Flush p and its run, stream restarts empty
              rel.req <= 1'b1;
              held    <= 1'b0;
              n       <= '0;
              state   <= carry_pkg::res_flush;
            end else begin
              bundle.ack <= 1'b1;
              state      <= carry_pkg::res_idle;
            end
          end else begin
            idx <= idx + 1'b1;
            if (!held) begin
              // First token, carry ignored
              held <= 1'b1;
              n    <= '0;
            end else if (!cur.carry && is_ff) begin
              n <= n + 1'b1;
            end else begin
              rel.req <= 1'b1;
              n       <= '0;
              state   <= carry_pkg::res_release;
            end
          end
        end

        carry_pkg::res_release,
        carry_pkg::res_flush: begin
          if (rel.req && rel.ack) begin
            rel.req <= 1'b0;
          end else if (!rel.req && !rel.ack) begin
            if (state == carry_pkg::res_flush) begin
              bundle.ack <= 1'b1;
              state      <= carry_pkg::res_idle;
            end else begin
              state <= carry_pkg::res_scan;
            end
          end
        end

        default: state <= carry_pkg::res_idle;
      endcase
    end
  end

  // ------------------------------
  // Held byte and release payload
  // ------------------------------
  always_ff @(posedge s4_clk) begin
    if (state == carry_pkg::res_scan) begin
      if (lanes_done) begin
        rel.head       <= p;
        rel.fill       <= {carry_pkg::byte_w{1'b1}};
        rel.count      <= n;
        rel.final_flag <= 1'b1;
      end else if (!held || cur.carry || !is_ff) begin
        p              <= cur.data;
        // A carry bumps p and turns the 0xFF run into zeros
        rel.head       <= cur.carry ? p + 1'b1 : p;
        rel.fill       <= cur.carry ? '0 : {carry_pkg::byte_w{1'b1}};
        rel.count      <= n;
        rel.final_flag <= 1'b0;
      end
    end
  end

  // Run counter never wraps
  a_run_no_wrap : assert property (@(posedge s4_clk) disable iff (rst)
    run_inc |=> (n != '0));

endmodule

`default_nettype wire

// File: hdl/run_emitter.sv
// Run emitter, serialises release commands into single output bytes
`timescale 1ns/100ps
`default_nettype none

module run_emitter #(
  parameter int RUN_WIDTH = 8
) (
  input  logic                         s4_clk,
  input  logic                         rst,
  release_if.consumer                  rel,
  output logic                         out_req,
  input  logic                         out_ack,
  output logic [carry_pkg::byte_w-1:0] out_byte,
  output logic                         out_last
);

  carry_pkg::emit_state_t       state;
  logic [carry_pkg::byte_w-1:0] fill;
  // Fill bytes still to send
  logic [RUN_WIDTH-1:0]         remaining;
  logic                         final_cmd;

  // ------------------------------
  // Output FSM
  // ------------------------------
  always_ff @(posedge s4_clk) begin
    if (rst) begin
      state    <= carry_pkg::emit_idle;
      out_req  <= 1'b0;
      out_last <= 1'b0;
      rel.ack  <= 1'b0;
    end else begin
      case (state)
        carry_pkg::emit_idle: begin
          if (rel.req && !rel.ack) begin
            // Head goes out first
            out_byte  <= rel.head;
            fill      <= rel.fill;
            remaining <= rel.count;
            final_cmd <= rel.final_flag;
            out_last  <= rel.final_flag && (rel.count == '0);
            out_req   <= 1'b1;
            state     <= carry_pkg::emit_req;
          end
        end

        carry_pkg::emit_req: begin
          if (out_ack) begin
            out_req <= 1'b0;
            state   <= carry_pkg::emit_ack_wait;
          end
        end

        carry_pkg::emit_ack_wait: begin
          if (!out_ack) begin
            if (remaining != '0) begin
              remaining <= remaining - 1'b1;
              out_byte  <= fill;
              out_last  <= final_cmd && (remaining == RUN_WIDTH'(1));
              out_req   <= 1'b1;
              state     <= carry_pkg::emit_req;
            end else begin
              // Whole command sent
              out_last <= 1'b0;
              rel.ack  <= 1'b1;
              state    <= carry_pkg::emit_done;
            end
          end
        end

        carry_pkg::emit_done: begin
          if (!rel.req) begin
            rel.ack <= 1'b0;
            state   <= carry_pkg::emit_idle;
          end
        end

        default: state <= carry_pkg::emit_idle;
      endcase
    end
  end

  // Byte and flag held until the consumer acknowledges
  a_out_stable : assert property (@(posedge s4_clk) disable iff (rst)
    (out_req && !out_ack) |=> $stable(out_byte) && $stable(out_last));

endmodule

`default_nettype wire

// File: hdl/carry_stage.sv
// Carry propagation stage, compactor, resolver and emitter in a three-stage pipeline
`timescale 1ns/100ps
`default_nettype none

module carry_stage #(
  parameter int RUN_WIDTH = 8
) (
  input  logic                                             s4_clk,
  input  logic                                             rst,
  // Input bundle, four-phase
  input  logic                                             in_req,
  output logic                                             in_ack,
  input  logic [carry_pkg::num_lanes-1:0]                  in_valid,
  input  logic [carry_pkg::num_lanes-1:0]                  in_carry,
  input  logic [carry_pkg::num_lanes*carry_pkg::byte_w-1:0] in_data,
  input  logic                                             in_last,
  // Output byte, four-phase
  output logic                                             out_req,
  input  logic                                             out_ack,
  output logic [carry_pkg::byte_w-1:0]                     out_byte,
  output logic                                             out_last
);

  // ------------------------------
  // Stage links
  // ------------------------------
  lane_bundle_if bundle_link ();

  release_if #(
    .RUN_WIDTH (RUN_WIDTH)
  ) rel_link ();

  // ------------------------------
  // Stages
  // ------------------------------
  lane_compactor i_compactor (
    .s4_clk   (s4_clk),
    .rst      (rst),
    .in_req   (in_req),
    .in_ack   (in_ack),
    .in_valid (in_valid),
    .in_carry (in_carry),
    .in_data  (in_data),
    .in_last  (in_last),
    .bundle   (bundle_link.producer)
  );

  carry_resolver #(
    .RUN_WIDTH (RUN_WIDTH)
  ) i_resolver (
    .s4_clk (s4_clk),
    .rst    (rst),
    .bundle (bundle_link.consumer),
    .rel    (rel_link.producer)
  );

  run_emitter #(
    .RUN_WIDTH (RUN_WIDTH)
  ) i_emitter (
    .s4_clk   (s4_clk),
    .rst      (rst),
    .rel      (rel_link.consumer),
    .out_req  (out_req),
    .out_ack  (out_ack),
    .out_byte (out_byte),
    .out_last (out_last)
  );

endmodule

`default_nettype wire

// File: verif/tb_carry_stage.sv
// Testbench for the carry stage with table-driven bundles checked against a reference model
`timescale 1ns/100ps
`default_nettype none

module tb_carry_stage;

  localparam int num_rows     = 16;
  localparam int num_tests    = 9;
  localparam int reset_cycles = 16;
  // Table length times 40 cycles for each of the two ack modes
  localparam int watchdog_cycles = reset_cycles + num_rows * 40 * 2;

  typedef struct packed {
    logic                              last;
    logic [carry_pkg::num_lanes-1:0]   valid;
    logic [carry_pkg::num_lanes-1:0]   carry;
    logic [carry_pkg::num_lanes*8-1:0] data;
  } row_t;

  logic        s4_clk;
  logic        rst;
  logic        in_req;
  logic        in_ack;
  logic [2:0]  in_valid;
  logic [2:0]  in_carry;
  logic [23:0] in_data;
  logic        in_last;
  logic        out_req;
  logic        out_ack;
  logic [7:0]  out_byte;
  logic        out_last;

  logic [7:0]  exp_bytes [$];
  logic        exp_last [$];
  int          test_end [num_tests];
  int          pass_bytes;
  int          pass_idx = 0;
  int          rx_count = 0;
  int          mismatches = 0;
  logic [31:0] rng = 32'd7;

  // Columns are last, valid, carry, data with lane 0 in the low byte
  row_t stim [num_rows] = '{
    '{1'b0, 3'b111, 3'b000, 24'h03_02_01},
    '{1'b1, 3'b111, 3'b000, 24'h06_05_04},
    '{1'b0, 3'b111, 3'b000, 24'hff_ff_10},
    '{1'b1, 3'b011, 3'b001, 24'h00_30_22},
    '{1'b1, 3'b011, 3'b010, 24'h00_05_ff},
    '{1'b0, 3'b111, 3'b000, 24'hff_ff_40},
    '{1'b1, 3'b011, 3'b000, 24'h00_41_ff},
    '{1'b0, 3'b101, 3'b000, 24'h52_00_50},
    '{1'b0, 3'b000, 3'b000, 24'h00_00_00},
    '{1'b0, 3'b100, 3'b000, 24'hff_00_00},
    '{1'b1, 3'b010, 3'b010, 24'h00_54_00},
    '{1'b0, 3'b111, 3'b000, 24'hff_52_50},
    '{1'b1, 3'b001, 3'b001, 24'h00_00_54},
    '{1'b1, 3'b111, 3'b000, 24'hff_ff_60},
    '{1'b1, 3'b011, 3'b001, 24'h00_71_70},
    '{1'b1, 3'b100, 3'b000, 24'h80_00_00}
  };

  string test_name [num_tests] = '{
    "plain bytes", "carry after ff run", "carry wraps ff", "ff run then plain",
    "lanes with gaps", "same tokens dense", "flush with run", "fresh start",
    "single token"
  };

  carry_stage #(
    .RUN_WIDTH (8)
  ) i_dut (
    .s4_clk   (s4_clk),
    .rst      (rst),
    .in_req   (in_req),
    .in_ack   (in_ack),
    .in_valid (in_valid),
    .in_carry (in_carry),
    .in_data  (in_data),
    .in_last  (in_last),
    .out_req  (out_req),
    .out_ack  (out_ack),
    .out_byte (out_byte),
    .out_last (out_last)
  );

  initial begin
    s4_clk = 1'b0;
    forever #4 s4_clk = ~s4_clk;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // ------------------------------
  // Reference model
  // ------------------------------
  task automatic expect_byte(input logic [7:0] b, input logic l);
    exp_bytes.push_back(b);
    exp_last.push_back(l);
  endtask

  task automatic build_expected();
    logic [7:0] p;
    logic [7:0] b;
    logic       c;
    logic       held;
    int         n;
    int         t;
    int         base;
    p    = '0;
    held = 1'b0;
    n    = 0;
    t    = 0;
    base = exp_bytes.size();
    for (int r = 0; r < num_rows; r++) begin
      for (int l = 0; l < carry_pkg::num_lanes; l++) begin
        if (stim[r].valid[l]) begin
          c = stim[r].carry[l];
          b = stim[r].data[l*8 +: 8];
          if (!held) begin
            p    = b;
            n    = 0;
            held = 1'b1;
          end else if (c) begin
            expect_byte(p + 8'd1, 1'b0);
            repeat (n) expect_byte(8'h00, 1'b0);
            p = b;
            n = 0;
          end else if (b == 8'hff) begin
            n++;
          end else begin
            expect_byte(p, 1'b0);
            repeat (n) expect_byte(8'hff, 1'b0);
            p = b;
            n = 0;
          end
        end
      end
      if (stim[r].last) begin
        // Flush the held byte and its run
        if (held) begin
          expect_byte(p, n == 0);
          for (int k = 1; k <= n; k++) begin
            expect_byte(8'hff, k == n);
          end
        end
        held        = 1'b0;
        n           = 0;
        test_end[t] = exp_bytes.size() - base;
        t++;
      end
    end
    pass_bytes = exp_bytes.size() - base;
  endtask

  // ------------------------------
  // Input and output handshakes
  // ------------------------------
  task automatic send_bundle(input row_t r);
    in_valid <= r.valid;
    in_carry <= r.carry;
    in_data  <= r.data;
    in_last  <= r.last;
    in_req   <= 1'b1;
    do begin
      @(posedge s4_clk);
    end while (!in_ack);
    in_req <= 1'b0;
    do begin
      @(posedge s4_clk);
    end while (in_ack);
  endtask

  task automatic check_byte();
    logic [7:0] want_b;
    logic       want_l;
    if (exp_bytes.size() == 0) begin
      $display("Extra output byte 0x%02h arrived after the expected stream ended", out_byte);
      mismatches++;
    end else begin
      want_b = exp_bytes.pop_front();
      want_l = exp_last.pop_front();
      if (out_byte !== want_b) begin
        $display("Fail out_byte: got 0x%02h, expected 0x%02h", out_byte, want_b);
        mismatches++;
      end
      if (out_last !== want_l) begin
        $display("Fail out_last: got 0x%0h, expected 0x%0h", out_last, want_l);
        mismatches++;
      end
    end
    rx_count++;
  endtask

  // Consumer with no delay in round 0 and 0 to 3 cycles in round 1
  initial begin : answer_output
    int delay;
    out_ack = 1'b0;
    forever begin
      @(posedge s4_clk);
      if (!rst && out_req && !out_ack) begin
        delay = 0;
        if (pass_idx == 1) begin
          rng   = xorshift32(rng);
          delay = int'(rng[1:0]);
        end
        repeat (delay) @(posedge s4_clk);
        check_byte();
        out_ack <= 1'b1;
        do begin
          @(posedge s4_clk);
        end while (out_req);
        out_ack <= 1'b0;
      end
    end
  end

  initial begin : watchdog
    repeat (watchdog_cycles) @(posedge s4_clk);
    $display("Timeout: the DUT stopped delivering bytes, %0d still expected", exp_bytes.size());
    $display("Simulation failed");
    $finish;
  end

  // ------------------------------
  // Stimulus
  // ------------------------------
  initial begin : stimulus
    int row;
    int target;
    int err_start;
    int tests_failed;
    rst          = 1'b1;
    in_req       = 1'b0;
    in_valid     = '0;
    in_carry     = '0;
    in_data      = '0;
    in_last      = 1'b0;
    tests_failed = 0;
    // One expected stream per ack mode
    build_expected();
    build_expected();
    repeat (reset_cycles) @(posedge s4_clk);
    rst <= 1'b0;
    @(posedge s4_clk);
    for (int r = 0; r < 2; r++) begin
      pass_idx = r;
      row      = 0;
      for (int t = 0; t < num_tests; t++) begin
        err_start = mismatches;
        do begin
          send_bundle(stim[row]);
          row++;
        end while (!stim[row-1].last);
        target = r * pass_bytes + test_end[t];
        while (rx_count < target) @(posedge s4_clk);
        if (mismatches != err_start) begin
          tests_failed++;
        end
        $display("Test %0d %-20s %-9s ack: %0d errors", t, test_name[t],
                 (r == 0) ? "immediate" : "random", mismatches - err_start);
      end
    end
    // Quiet period to catch any extra byte
    repeat (20) @(posedge s4_clk);
    $display("Tests run %0d, failed %0d, bytes checked %0d, errors %0d",
             2 * num_tests, tests_failed, rx_count, mismatches);
    if (tests_failed == 0 && mismatches == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: carry_stage.f
hdl/carry_pkg.sv
hdl/lane_bundle_if.sv
hdl/release_if.sv
hdl/lane_compactor.sv
hdl/carry_resolver.sv
hdl/run_emitter.sv
hdl/carry_stage.sv
verif/tb_carry_stage.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert --timescale 1ns/100ps -j 0
TOP       ?= tb_carry_stage
FILELIST  ?= carry_stage.f
OBJDIR    ?= obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Simulation passed"

clean:
	rm -rf $(OBJDIR)
